//--- src.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_ifs.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_csr_file.sv
hw/rv_memory.sv
hw/rv_core_top.sv
verification/rv_clk_gen.sv
verification/rv_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_pkg.sv
      - hw/rv_ifs.sv
      - hw/rv_decoder.sv
      - hw/rv_regfile.sv
      - hw/rv_execute.sv
      - hw/rv_csr_file.sv
      - hw/rv_memory.sv
      - hw/rv_core_top.sv
      - target: test
        files:
          - verification/rv_clk_gen.sv
          - verification/rv_tb.sv

//--- verification/rv_tb.sv
`include "rv_defs.svh"

module rv_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int M_IDLE = 0;
    localparam int M_RUN  = 1;
    localparam int M_HALT = 2;
    localparam logic [31:0] ECALL  = 32'h0000_0073;
    localparam logic [31:0] EBREAK = 32'h0010_0073;
    localparam logic [31:0] MRET   = 32'h3020_0073;

    logic        clk, por_n, hold_n, rst_n, load_en;
    logic [31:0] load_addr, load_data, pc, retire_data, halt_code;
    logic [4:0]  retire_rd;
    logic        retire_valid, halt;

    // reference model state.
    logic [31:0] m_mem [0:1023];
    logic [31:0] m_x [0:31];
    logic [31:0] m_pc, m_mepc, m_mcause, m_mstatus, m_mtvec, m_code, e_data;
    logic [4:0]  e_rd;
    int          m_state;
    bit          m_live;

    logic [31:0] prog [$];
    logic [31:0] lfsr = 32'd35;
    int          f3s [5] = '{0, 7, 6, 4, 2};
    int          errors;

    assign rst_n = por_n & hold_n;

    rv_clk_gen u_clk (.clk(clk), .rst_n(por_n));

    rv_core_top dut0 (
        .clk(clk), .rst_n(rst_n), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .pc(pc), .retire_valid(retire_valid),
        .retire_rd(retire_rd), .retire_data(retire_data), .halt(halt),
        .halt_code(halt_code)
    );

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] imm, rd);
        return {imm[19:0], rd[4:0], 7'h37};
    endfunction

    // lui plus addi with the upper part rounded for the sign of the low 12 bits.
    task automatic put_const(input logic [31:0] rd, input logic [31:0] v);
        prog.push_back(enc_u((v + 32'h800) >> 12, rd));
        prog.push_back(enc_i(v, rd, 0, rd, 7'h13));
    endtask

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic sub,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd7:    return a & b;
            3'd6:    return a | b;
            3'd4:    return a ^ b;
            default: return {31'd0, $signed(a) < $signed(b)};
        endcase
    endfunction

    function automatic logic [31:0] csr_value(input logic [11:0] addr);
        case (addr)
            `RV_CSR_MEPC:    return m_mepc;
            `RV_CSR_MCAUSE:  return m_mcause;
            `RV_CSR_MSTATUS: return m_mstatus;
            `RV_CSR_MTVEC:   return m_mtvec;
            default:         return '0;
        endcase
    endfunction

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] v);
        case (addr)
            `RV_CSR_MEPC:    m_mepc    = v;
            `RV_CSR_MCAUSE:  m_mcause  = v;
            `RV_CSR_MSTATUS: m_mstatus = v;
            `RV_CSR_MTVEC:   m_mtvec   = v;
            default:         ;
        endcase
    endtask

    // one instruction at m_pc; commit applies its effects.
    task automatic exec_model(input bit commit);
        logic [31:0] w, a, b, imm, res, nxt, old, addr;
        logic [2:0]  f3;
        logic        wr;
        int          cause;
        w     = m_mem[m_pc[11:2]];
        f3    = w[14:12];
        a     = m_x[w[19:15]];
        b     = m_x[w[24:20]];
        imm   = {{20{w[31]}}, w[31:20]};
        old   = csr_value(w[31:20]);
        res   = '0;
        wr    = 1'b1;
        nxt   = m_pc + 32'd4;
        cause = 0;
        case (w[6:0])
            7'h13: res = alu(f3, 1'b0, a, imm);
            7'h33: res = alu(f3, w[30], a, b);
            7'h37: res = {w[31:12], 12'd0};
            7'h03: begin
                addr = a + imm;
                res  = m_mem[addr[11:2]];
            end
            7'h23: begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                wr   = 1'b0;
                if (commit) begin
                    m_mem[addr[11:2]] = b;
                end
            end
            7'h63: begin
                wr = 1'b0;
                if ((a == b) != f3[0]) begin
                    nxt = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'h6f: begin
                res = m_pc + 32'd4;
                nxt = m_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                res = m_pc + 32'd4;
                nxt = (a + imm) & ~32'd1;
            end
            7'h73: begin
                wr = 1'b0;
                if (f3 == 3'd1 || f3 == 3'd2) begin
                    wr  = 1'b1;
                    res = old;
                    if (commit) begin
                        csr_write(w[31:20], f3[1] ? (old | a) : a);
                    end
                end else if (w == ECALL) begin
                    cause = 11;
                end else if (w == MRET) begin
                    nxt = m_mepc;
                end else if (w == EBREAK) begin
                    nxt = m_pc;
                    if (commit) begin
                        m_state = M_HALT;
                        m_code  = m_x[10];
                    end
                end else begin
                    cause = 2;
                end
            end
            default: cause = 2;
        endcase
        if (cause != 0) begin
            wr  = 1'b0;
            nxt = m_mtvec;
            if (commit) begin
                m_mepc   = m_pc;
                m_mcause = cause;
            end
        end
        if (w[11:7] == 5'd0) begin
            wr = 1'b0;
        end
        e_rd   = wr ? w[11:7] : 5'd0;
        e_data = wr ? res : 32'd0;
        if (commit) begin
            if (wr) begin
                m_x[w[11:7]] = res;
            end
            m_pc = nxt;
        end
    endtask

    // model steps on the same edge as the core.
    always @(posedge clk) begin
        if (!rst_n) begin
            m_state   = M_IDLE;
            m_pc      = `RV_RESET_VEC;
            m_mepc    = '0;
            m_mcause  = '0;
            m_mstatus = '0;
            m_mtvec   = '0;
            m_code    = '0;
            for (int i = 0; i < 32; i++) begin
                m_x[i] = '0;
            end
            m_live = 1'b1;
        end else if (m_state == M_RUN) begin
            exec_model(1'b1);
        end else if (m_state == M_IDLE) begin
            m_state = M_RUN;
        end
        e_rd   = '0;
        e_data = '0;
        if (m_state == M_RUN) begin
            exec_model(1'b0);
        end
    end

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
        errors++;
    endtask

    a_pc: assert property (@(posedge clk) !m_live || pc === m_pc)
        else mismatch("pc", $sampled(m_pc), $sampled(pc));
    a_valid: assert property (@(posedge clk) !m_live || retire_valid === (m_state == M_RUN))
        else mismatch("retire_valid", $sampled(m_state == M_RUN), $sampled(retire_valid));
    a_rd: assert property (@(posedge clk) !m_live || retire_rd === e_rd)
        else mismatch("retire_rd", $sampled(e_rd), $sampled(retire_rd));
    a_data: assert property (@(posedge clk) !m_live || retire_data === e_data)
        else mismatch("retire_data", $sampled(e_data), $sampled(retire_data));
    a_halt: assert property (@(posedge clk) !m_live || halt === (m_state == M_HALT))
        else mismatch("halt", $sampled(m_state == M_HALT), $sampled(halt));
    a_code: assert property (@(posedge clk) !m_live || halt_code === m_code)
        else mismatch("halt_code", $sampled(m_code), $sampled(halt_code));

    // load under reset, release, wait for ebreak, then watch a few frozen cycles.
    task automatic run_prog(input string name);
        int n;
        int errs0;
        errs0 = errors;
        @(negedge clk);
        hold_n = 1'b0;
        @(negedge clk);
        for (n = 0; n < prog.size(); n++) begin
            load_en   = 1'b1;
            load_addr = n;
            load_data = prog[n];
            m_mem[n]  = prog[n];
            @(negedge clk);
        end
        load_en = 1'b0;
        hold_n  = 1'b1;
        n = 0;
        while (!rst_n && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("%s: reset was never released", name);
            errors++;
        end
        n = 0;
        while (!halt && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (!halt) begin
            $display("%s: core never halted within 400 cycles", name);
            errors++;
        end
        repeat (4) @(negedge clk);
        $display("test %s finished with %0d errors", name, errors - errs0);
        prog.delete();
    endtask

    task automatic test_reset();
        prog.push_back(enc_i(1, 0, 0, 1, 7'h13));
        prog.push_back(enc_i(2, 1, 0, 2, 7'h13));
        prog.push_back(enc_r(0, 2, 1, 0, 10));
        prog.push_back(enc_i(0, 0, 0, 0, 7'h13));
        prog.push_back(EBREAK);
        run_prog("reset");
    endtask

    task automatic test_alu();
        logic [31:0] k, rd, rs1, rs2, imm;
        for (int j = 1; j < 8; j++) begin
            put_const(j, take_bits(32));
        end
        for (int j = 0; j < 24; j++) begin
            k   = take_bits(4) % 12;
            rd  = take_bits(3);
            rs1 = take_bits(3);
            rs2 = take_bits(3);
            imm = take_bits(12);
            if (k < 5) begin
                prog.push_back(enc_i(imm, rs1, f3s[k], rd, 7'h13));
            end else if (k == 5) begin
                prog.push_back(enc_u(take_bits(20), rd));
            end else if (k == 6) begin
                prog.push_back(enc_r(7'h20, rs2, rs1, 0, rd));
            end else begin
                prog.push_back(enc_r(0, rs2, rs1, f3s[k - 7], rd));
            end
        end
        // x0 is written here and read back by the or below.
        prog.push_back(enc_i(32'h7ff, 1, 0, 0, 7'h13));
        prog.push_back(enc_r(0, 1, 0, 6, 10));
        prog.push_back(EBREAK);
        run_prog("alu");
    endtask

    task automatic test_memory();
        logic [31:0] offs [6];
        for (int j = 0; j < 6; j++) begin
            put_const(1, take_bits(32));
            offs[j] = 32'h400 + (take_bits(6) << 2);
            prog.push_back(enc_s(offs[j], 1, 0));
        end
        for (int j = 5; j >= 0; j--) begin
            prog.push_back(enc_i(offs[j], 0, 2, (j == 0) ? 10 : 2 + j, 7'h03));
        end
        prog.push_back(EBREAK);
        run_prog("memory");
    endtask

    task automatic test_control();
        prog.push_back(enc_i(3, 0, 0, 1, 7'h13));
        prog.push_back(enc_i(3, 0, 0, 2, 7'h13));
        prog.push_back(enc_i(4, 0, 0, 3, 7'h13));
        prog.push_back(enc_b(8, 2, 1, 0));
        prog.push_back(enc_i(1, 0, 0, 10, 7'h13));
        prog.push_back(enc_b(8, 3, 1, 0));
        prog.push_back(enc_b(8, 3, 1, 1));
        prog.push_back(enc_i(2, 0, 0, 10, 7'h13));
        prog.push_back(enc_b(8, 2, 1, 1));
        prog.push_back(enc_j(8, 5));
        prog.push_back(enc_i(3, 0, 0, 10, 7'h13));
        // odd offset still lands on word 13.
        prog.push_back(enc_i(13, 5, 0, 6, 7'h67));
        prog.push_back(enc_i(4, 0, 0, 10, 7'h13));
        prog.push_back(enc_i(9, 10, 0, 10, 7'h13));
        prog.push_back(EBREAK);
        run_prog("control");
    endtask

    task automatic test_traps();
        prog.push_back(enc_u(32'h80000, 1));
        prog.push_back(enc_i(40, 1, 0, 1, 7'h13));
        prog.push_back(enc_i(`RV_CSR_MTVEC, 1, 1, 0, 7'h73));
        prog.push_back(enc_i(`RV_CSR_MTVEC, 0, 2, 4, 7'h73));
        prog.push_back(ECALL);
        prog.push_back(enc_r(0, 0, 3, 0, 10));
        prog.push_back(32'hffff_ffff);
        prog.push_back(enc_r(0, 3, 10, 0, 10));
        prog.push_back(EBREAK);
        prog.push_back(enc_i(0, 0, 0, 0, 7'h13));
        // handler at word 10 steps mepc past the trapping word.
        prog.push_back(enc_i(`RV_CSR_MEPC, 0, 2, 2, 7'h73));
        prog.push_back(enc_i(`RV_CSR_MCAUSE, 0, 2, 3, 7'h73));
        prog.push_back(enc_i(4, 2, 0, 2, 7'h13));
        prog.push_back(enc_i(`RV_CSR_MEPC, 2, 1, 0, 7'h73));
        prog.push_back(MRET);
        run_prog("traps");
    endtask

    task automatic test_halt();
        put_const(10, take_bits(32));
        prog.push_back(EBREAK);
        prog.push_back(enc_i(1, 0, 0, 10, 7'h13));
        run_prog("halt");
    endtask

    initial begin
        hold_n    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        errors    = 0;
        test_reset();
        test_alu();
        test_memory();
        test_control();
        test_traps();
        test_halt();
        $display("6 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

//--- verification/rv_clk_gen.sv
module rv_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // power-on reset is released on a falling edge.
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

//--- hw/rv_core_top.sv
`include "rv_defs.svh"

module rv_core_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    output logic [31:0] pc,
    output logic        retire_valid,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_data,
    output logic        halt,
    output logic [31:0] halt_code
);
    import rv_pkg::*;

    core_state_e state;
    logic [31:0] inst, a0, exe_result, npc, csr_rdata, mtvec, mepc, wb_data;
    logic        running, rf_wen;

    decode_if dec_bus ();
    dmem_if   dmem_bus ();

    assign running = (state == st_run);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            pc        <= `RV_RESET_VEC;
            halt_code <= '0;
        end else begin
            case (state)
                st_idle: state <= st_run;
                st_run: begin
                    pc <= npc;
                    if (dec_bus.dec.cls == cls_ebreak) begin
                        state     <= st_halt;
                        halt_code <= a0;
                    end
                end
                default: state <= st_halt;
            endcase
        end
    end

    always_comb begin
        case (dec_bus.dec.cls)
            cls_jal, cls_jalr: wb_data = pc + 32'd4;
            cls_load:          wb_data = dmem_bus.rdata;
            default:           wb_data = exe_result;
        endcase
    end

    assign rf_wen         = dec_bus.dec.rd_wen && running;
    assign dmem_bus.wen   = (dec_bus.dec.cls == cls_store) && running;
    assign dmem_bus.wdata = dec_bus.rs2_val;

    assign retire_valid = running;
    assign retire_rd    = rf_wen ? dec_bus.dec.rd : 5'd0;
    assign retire_data  = rf_wen ? wb_data : 32'd0;
    assign halt         = (state == st_halt);

    rv_memory u_mem (
        .clk(clk), .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .fetch_addr(pc), .fetch_data(inst), .dmem(dmem_bus.mem)
    );

    rv_decoder u_dec (
        .inst(inst), .dec(dec_bus.dec_src)
    );

    rv_regfile u_rf (
        .clk(clk), .rst_n(rst_n), .dec(dec_bus.rf_src), .wen(rf_wen),
        .waddr(dec_bus.dec.rd), .wdata(wb_data), .a0(a0)
    );

    rv_execute u_exe (
        .pc(pc), .dec(dec_bus.dec_snk), .csr_rdata(csr_rdata), .trap_vec(mtvec),
        .epc(mepc), .dmem(dmem_bus.core), .result(exe_result), .npc(npc)
    );

    rv_csr_file u_csr (
        .clk(clk), .rst_n(rst_n), .pc(pc), .dec(dec_bus.dec_snk),
        .rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc)
    );
endmodule

//--- hw/rv_memory.sv
`include "rv_defs.svh"

module rv_memory (
    input  logic        clk,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data,
    input  logic [31:0] fetch_addr,
    output logic [31:0] fetch_data,
    dmem_if.mem         dmem
);
    localparam int AW = $clog2(`RV_MEM_WORDS);

    logic [31:0]   mem [0:`RV_MEM_WORDS-1];
    logic [AW-1:0] fetch_idx, data_idx;

    // upper address bits wrap, so the reset vector lands on word 0.
    assign fetch_idx = fetch_addr[AW+1:2];
    assign data_idx  = dmem.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[AW-1:0]] <= load_data;
        end else if (dmem.wen) begin
            mem[data_idx] <= dmem.wdata;
        end
    end

    assign fetch_data = mem[fetch_idx];
    assign dmem.rdata = mem[data_idx];
endmodule

//--- hw/rv_csr_file.sv
module rv_csr_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pc,
    decode_if.dec_snk   dec,
    output logic [31:0] rdata,
    output logic [31:0] mtvec,
    output logic [31:0] mepc
);
    import rv_pkg::*;

    logic [31:0] mcause, mstatus, wval;

    always_comb begin
        case (dec.dec.csr_sel)
            csr_mepc:    rdata = mepc;
            csr_mcause:  rdata = mcause;
            csr_mstatus: rdata = mstatus;
            csr_mtvec:   rdata = mtvec;
            default:     rdata = '0;
        endcase
    end

    assign wval = (dec.dec.alu_op == alu_or) ? (rdata | dec.rs1_val) : dec.rs1_val;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= '0;
            mtvec   <= '0;
        end else if (dec.dec.cls == cls_ecall || dec.dec.cls == cls_illegal) begin
            mepc <= pc;
            // 11 is ecall from m-mode, 2 is illegal instruction.
            mcause <= (dec.dec.cls == cls_ecall) ? 32'd11 : 32'd2;
        end else if (dec.dec.cls == cls_csr) begin
            case (dec.dec.csr_sel)
                csr_mepc:    mepc    <= wval;
                csr_mcause:  mcause  <= wval;
                csr_mstatus: mstatus <= wval;
                csr_mtvec:   mtvec   <= wval;
                default:     ;
            endcase
        end
    end
endmodule

//--- hw/rv_execute.sv
module rv_execute (
    input  logic [31:0] pc,
    decode_if.dec_snk   dec,
    input  logic [31:0] csr_rdata,
    input  logic [31:0] trap_vec,
    input  logic [31:0] epc,
    dmem_if.core        dmem,
    output logic [31:0] result,
    output logic [31:0] npc
);
    import rv_pkg::*;

    logic [31:0] op_a, op_b, alu_out, pc_seq, pc_rel;
    logic        br_taken;

    assign op_a = dec.rs1_val;
    assign op_b = dec.dec.use_imm ? dec.dec.imm : dec.rs2_val;

    always_comb begin
        case (dec.dec.alu_op)
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_slt:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // loads and stores use the add result as address.
    assign dmem.addr = alu_out;
    // csr instructions return the old csr value.
    assign result = (dec.dec.cls == cls_csr) ? csr_rdata : alu_out;

    assign br_taken = (dec.rs1_val == dec.rs2_val) ^ dec.dec.branch_ne;
    assign pc_seq   = pc + 32'd4;
    assign pc_rel   = pc + dec.dec.imm;

    always_comb begin
        case (dec.dec.cls)
            cls_branch:             npc = br_taken ? pc_rel : pc_seq;
            cls_jal:                npc = pc_rel;
            cls_jalr:               npc = {alu_out[31:1], 1'b0};
            cls_ecall, cls_illegal: npc = trap_vec;
            cls_mret:               npc = epc;
            cls_ebreak:             npc = pc;
            default:                npc = pc_seq;
        endcase
    end
endmodule

//--- hw/rv_regfile.sv
module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    decode_if.rf_src    dec,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] a0
);
    logic [31:0] regs [0:31];

    // x0 never written, so it reads back zero.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign dec.rs1_val = (dec.dec.rs1 == 5'd0) ? 32'd0 : regs[dec.dec.rs1];
    assign dec.rs2_val = (dec.dec.rs2 == 5'd0) ? 32'd0 : regs[dec.dec.rs2];

    assign a0 = regs[10];
endmodule

//--- hw/rv_decoder.sv
`include "rv_defs.svh"

module rv_decoder (
    input  logic [31:0] inst,
    decode_if.dec_src   dec
);
    import rv_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    dec_t        d;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        d.cls       = cls_illegal;
        d.alu_op    = alu_add;
        d.csr_sel   = csr_none;
        d.rs1       = inst[19:15];
        d.rs2       = inst[24:20];
        d.rd        = inst[11:7];
        d.imm       = imm_i;
        d.use_imm   = 1'b0;
        d.branch_ne = 1'b0;
        d.rd_wen    = 1'b0;
        case (opcode)
            op_op_imm: begin
                d.cls     = cls_alu_imm;
                d.use_imm = 1'b1;
                d.rd_wen  = 1'b1;
                case (funct3)
                    3'b000:  d.alu_op = alu_add;
                    3'b111:  d.alu_op = alu_and;
                    3'b110:  d.alu_op = alu_or;
                    3'b100:  d.alu_op = alu_xor;
                    3'b010:  d.alu_op = alu_slt;
                    default: d.cls    = cls_illegal;
                endcase
            end
            op_op: begin
                d.cls    = cls_alu_reg;
                d.rd_wen = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: d.alu_op = alu_add;
                    10'b0100000_000: d.alu_op = alu_sub;
                    10'b0000000_111: d.alu_op = alu_and;
                    10'b0000000_110: d.alu_op = alu_or;
                    10'b0000000_100: d.alu_op = alu_xor;
                    10'b0000000_010: d.alu_op = alu_slt;
                    default:         d.cls    = cls_illegal;
                endcase
            end
            op_lui: begin
                d.cls     = cls_lui;
                d.alu_op  = alu_pass_b;
                d.imm     = imm_u;
                d.use_imm = 1'b1;
                d.rd_wen  = 1'b1;
            end
            op_load: begin
                d.cls     = (funct3 == 3'b010) ? cls_load : cls_illegal;
                d.use_imm = 1'b1;
                d.rd_wen  = 1'b1;
            end
            op_store: begin
                d.cls     = (funct3 == 3'b010) ? cls_store : cls_illegal;
                d.imm     = imm_s;
                d.use_imm = 1'b1;
            end
            op_branch: begin
                d.cls       = (funct3[2:1] == 2'b00) ? cls_branch : cls_illegal;
                d.imm       = imm_b;
                d.branch_ne = funct3[0];
            end
            op_jal: begin
                d.cls    = cls_jal;
                d.imm    = imm_j;
                d.rd_wen = 1'b1;
            end
            op_jalr: begin
                d.cls     = (funct3 == 3'b000) ? cls_jalr : cls_illegal;
                d.use_imm = 1'b1;
                d.rd_wen  = 1'b1;
            end
            op_system: begin
                if (inst == 32'h0000_0073) begin
                    d.cls = cls_ecall;
                end else if (inst == 32'h0010_0073) begin
                    d.cls = cls_ebreak;
                end else if (inst == 32'h3020_0073) begin
                    d.cls = cls_mret;
                end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
                    d.cls    = cls_csr;
                    d.rd_wen = 1'b1;
                    // csrrs is carried as an or, csrrw as a plain copy.
                    d.alu_op = funct3[1] ? alu_or : alu_pass_b;
                    case (inst[31:20])
                        `RV_CSR_MEPC:    d.csr_sel = csr_mepc;
                        `RV_CSR_MCAUSE:  d.csr_sel = csr_mcause;
                        `RV_CSR_MSTATUS: d.csr_sel = csr_mstatus;
                        `RV_CSR_MTVEC:   d.csr_sel = csr_mtvec;
                        default:         d.csr_sel = csr_none;
                    endcase
                end
            end
            default: d.cls = cls_illegal;
        endcase
        if (d.cls == cls_illegal || d.rd == 5'd0) begin
            d.rd_wen = 1'b0;
        end
    end

    assign dec.dec = d;
endmodule

//--- hw/rv_ifs.sv
// decoded instruction plus the two register operands.
interface decode_if;
    import rv_pkg::*;

    dec_t        dec;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;

    modport dec_src (
        output dec
    );

    modport rf_src (
        input  dec,
        output rs1_val,
        output rs2_val
    );

    modport dec_snk (
        input dec,
        input rs1_val,
        input rs2_val
    );
endinterface

// data side of the unified memory.
interface dmem_if;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;
    logic [31:0] rdata;

    modport core (
        output addr
    );

    modport mem (
        input  addr,
        input  wdata,
        input  wen,
        output rdata
    );
endinterface

//--- hw/rv_pkg.sv
package rv_pkg;

    typedef enum logic [6:0] {
        op_op_imm = 7'b0010011,
        op_op     = 7'b0110011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        cls_alu_imm, cls_alu_reg, cls_lui, cls_load, cls_store,
        cls_branch, cls_jal, cls_jalr, cls_csr, cls_ecall,
        cls_mret, cls_ebreak, cls_illegal
    } inst_class_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        csr_mepc, csr_mcause, csr_mstatus, csr_mtvec, csr_none
    } csr_sel_e;

    typedef enum logic [1:0] {
        st_idle, st_run, st_halt
    } core_state_e;

    typedef struct packed {
        inst_class_e cls;
        alu_op_e     alu_op;
        csr_sel_e    csr_sel;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        use_imm;
        logic        branch_ne;
        logic        rd_wen;
    } dec_t;

endpackage

//--- hw/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// first fetch address after reset.
`define RV_RESET_VEC 32'h8000_0000

// unified memory depth in 32-bit words.
`define RV_MEM_WORDS 1024

// machine csr addresses.
`define RV_CSR_MEPC    12'h341
`define RV_CSR_MCAUSE  12'h342
`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MTVEC   12'h305

`endif
